/* hw/dcache_pkg.sv */
// cache geometry constants, address and line types, request opcode enum

package dcache_pkg;

  // fixed by the three-bit pseudo-LRU tree
  localparam int NUM_WAYS = 4;

  // byte offset within one 64-bit doubleword
  localparam int OFFSET_BITS = 3;

  localparam int ADDR_BITS = 32;

  // tag keeps every address bit above the offset, index bits included
  localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS;

  typedef logic [ADDR_BITS-1:0] addr_t;

  // stored state of one cache line
  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [TAG_BITS-1:0] tag;
    logic [63:0]         data;
  } line_t;

  // processor-side request kinds
  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_fill  = 2'd2
  } req_op_e;

endpackage

/* hw/writeback_pkg.sv */
// write-back entry type and credit counter width

package writeback_pkg;

  // wide enough for any buffer depth up to 15
  localparam int CREDIT_BITS = 4;

  // one evicted dirty line on its way to memory
  typedef struct packed {
    dcache_pkg::addr_t addr;
    logic [63:0]       data;
  } wb_entry_t;

endpackage

/* hw/writeback_if.sv */
// credit-based write-back channel with source and sink modports

`timescale 1ns/100ps

interface writeback_if;

  // one-cycle transfer strobe
  logic push;

  // payload, valid while push is high
  writeback_pkg::wb_entry_t entry;

  // one-cycle pulse back to the source when the sink frees a slot
  logic credit;

  modport source (
    output push,
    output entry,
    input  credit
  );

  modport sink (
    input  push,
    input  entry,
    output credit
  );

endinterface

/* hw/cache_way.sv */
// one cache way: tag, data, valid and dirty storage with hit and line read-out

`timescale 1ns/100ps

module cache_way #(
  parameter int NUM_SETS = 16
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              wr_en,
  input  logic              wr_dirty,
  input  dcache_pkg::addr_t addr,
  input  logic [63:0]       wr_data,
  output logic              hit,
  output dcache_pkg::line_t rd_line
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS = dcache_pkg::TAG_BITS;

  logic [INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]   tag;

  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;
  logic [TAG_BITS-1:0] tag_mem  [NUM_SETS];
  logic [63:0]         data_mem [NUM_SETS];

  // set index sits right above the byte offset
  assign index = addr[dcache_pkg::OFFSET_BITS +: INDEX_BITS];
  assign tag   = addr[dcache_pkg::OFFSET_BITS +: TAG_BITS];

  assign hit = valid_q[index] && (tag_mem[index] == tag);

  // indexed line, used for load data and for victim inspection
  assign rd_line.valid = valid_q[index];
  assign rd_line.dirty = dirty_q[index];
  assign rd_line.tag   = tag_mem[index];
  assign rd_line.data  = data_mem[index];

  // line status
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en) begin
      valid_q[index] <= 1'b1;
      dirty_q[index] <= wr_dirty;
    end
  end

  // tag and data arrays
  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_mem[index]  <= tag;
      data_mem[index] <= wr_data;
    end
  end

endmodule

/* hw/dcache.sv */
// 4-way data cache: request handling, way select, pseudo-LRU, victim choice, write-back push

`timescale 1ns/100ps

module dcache #(
  parameter int NUM_SETS = 16,
  parameter int WB_DEPTH = 4
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                req_valid,
  input  dcache_pkg::req_op_e req_op,
  input  dcache_pkg::addr_t   req_addr,
  input  logic [63:0]         req_data,
  output logic                req_ready,
  output logic                resp_valid,
  output logic                resp_hit,
  output logic [63:0]         resp_data,
  writeback_if.source         wb
);

  localparam int NUM_WAYS = dcache_pkg::NUM_WAYS;
  localparam int WAY_BITS = $clog2(NUM_WAYS);
  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int CREDIT_BITS = writeback_pkg::CREDIT_BITS;

  logic [INDEX_BITS-1:0]  set_idx;
  logic                   accept;
  logic                   evict;
  logic [NUM_WAYS-1:0]    hit_vec;
  logic [NUM_WAYS-1:0]    way_wr;
  logic                   any_hit;
  logic [WAY_BITS-1:0]    hit_way;
  logic [WAY_BITS-1:0]    victim_way;
  dcache_pkg::line_t      way_line [NUM_WAYS];
  dcache_pkg::line_t      victim_line;
  logic [NUM_SETS-1:0]    plru_a, plru_b, plru_c;
  logic [CREDIT_BITS-1:0] credit_count;

  assign set_idx   = req_addr[dcache_pkg::OFFSET_BITS +: INDEX_BITS];
  assign req_ready = (credit_count != '0);
  assign accept    = req_valid && req_ready;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_way #(.NUM_SETS(NUM_SETS)) u_way (
      .clock    (clock),
      .reset    (reset),
      .wr_en    (way_wr[w]),
      .wr_dirty (req_op == dcache_pkg::op_store),
      .addr     (req_addr),
      .wr_data  (req_data),
      .hit      (hit_vec[w]),
      .rd_line  (way_line[w])
    );
  end

  always_comb begin
    any_hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        any_hit = 1'b1;
        hit_way = WAY_BITS'(w);
      end
    end
  end

  // tree decode: a picks the half, then b or c picks the way
  assign victim_way  = plru_a[set_idx] ? {1'b1, plru_c[set_idx]} : {1'b0, plru_b[set_idx]};
  assign victim_line = way_line[victim_way];

  // stores only on a hit; fills go to the hit way, else the victim
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_wr[w] = 1'b0;
      if (accept) begin
        case (req_op)
          dcache_pkg::op_store: way_wr[w] = hit_vec[w];
          dcache_pkg::op_fill:  way_wr[w] = any_hit ? hit_vec[w] : (victim_way == WAY_BITS'(w));
          default:              way_wr[w] = 1'b0;
        endcase
      end
    end
  end

  assign evict = accept && (req_op == dcache_pkg::op_fill) && !any_hit &&
                 victim_line.valid && victim_line.dirty;

  // tree only moves on fills
  always_ff @(posedge clock) begin
    if (reset) begin
      plru_a <= '0;
      plru_b <= '0;
      plru_c <= '0;
    end else if (accept && (req_op == dcache_pkg::op_fill)) begin
      plru_a[set_idx] <= ~plru_a[set_idx];
      if (!plru_a[set_idx]) begin
        plru_b[set_idx] <= ~plru_b[set_idx];
      end else begin
        plru_c[set_idx] <= ~plru_c[set_idx];
      end
    end
  end

  // slot reserved at acceptance, so the push a cycle later always has room
  always_ff @(posedge clock) begin
    if (reset) begin
      credit_count <= CREDIT_BITS'(WB_DEPTH);
      resp_valid   <= 1'b0;
      wb.push      <= 1'b0;
    end else begin
      credit_count <= credit_count - CREDIT_BITS'(evict) + CREDIT_BITS'(wb.credit);
      resp_valid   <= accept;
      wb.push      <= evict;
    end
  end

  always_ff @(posedge clock) begin
    resp_hit      <= any_hit;
    resp_data     <= way_line[hit_way].data;
    wb.entry.addr <= {victim_line.tag, {dcache_pkg::OFFSET_BITS{1'b0}}};
    wb.entry.data <= victim_line.data;
  end

  // slot of a push stays taken in the count until the buffer returns it
  a_push_has_credit: assert property (
    @(posedge clock) disable iff (reset) wb.push |-> credit_count < CREDIT_BITS'(WB_DEPTH)
  );

  // tags are unique across the four ways of a set
  a_single_hit: assert property (
    @(posedge clock) disable iff (reset) req_valid |-> $onehot0(hit_vec)
  );

endmodule

/* hw/writeback_buffer.sv */
// circular FIFO of pending write-backs with credit return upstream

`timescale 1ns/100ps

module writeback_buffer #(
  parameter int WB_DEPTH = 4
) (
  input logic       clock,
  input logic       reset,
  writeback_if.sink   in_wb,
  writeback_if.source out_wb
);

  localparam int PTR_BITS = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
  localparam int CREDIT_BITS = writeback_pkg::CREDIT_BITS;
  localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(WB_DEPTH - 1);

  writeback_pkg::wb_entry_t fifo_mem [WB_DEPTH];

  logic [PTR_BITS-1:0]    head, tail;
  logic [CREDIT_BITS-1:0] count;
  logic [CREDIT_BITS-1:0] out_credit;
  logic                   send;

  // wraps at the last slot, depth need not be a power of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
  endfunction

  // head goes out once the drain has a free slot
  assign send = (count != '0) && (out_credit != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      head          <= '0;
      tail          <= '0;
      count         <= '0;
      out_credit    <= CREDIT_BITS'(1);
      out_wb.push   <= 1'b0;
      in_wb.credit  <= 1'b0;
    end else begin
      if (in_wb.push) begin
        tail <= next_ptr(tail);
      end
      if (send) begin
        head <= next_ptr(head);
      end
      count        <= count + CREDIT_BITS'(in_wb.push) - CREDIT_BITS'(send);
      out_credit   <= out_credit - CREDIT_BITS'(send) + CREDIT_BITS'(out_wb.credit);
      out_wb.push  <= send;
      // slot frees as the entry leaves
      in_wb.credit <= send;
    end
  end

  always_ff @(posedge clock) begin
    if (in_wb.push) begin
      fifo_mem[tail] <= in_wb.entry;
    end
    if (send) begin
      out_wb.entry <= fifo_mem[head];
    end
  end

  // upstream credit accounting must keep the FIFO from overflowing
  a_no_push_when_full: assert property (
    @(posedge clock) disable iff (reset) in_wb.push |-> count < WB_DEPTH
  );

endmodule

/* hw/writeback_drain.sv */
// single-entry drain stage issuing write-backs to memory against memory credits

`timescale 1ns/100ps

module writeback_drain #(
  parameter int MEM_CREDITS = 2
) (
  input  logic              clock,
  input  logic              reset,
  writeback_if.sink         in_wb,
  output logic              mem_wb_valid,
  output dcache_pkg::addr_t mem_wb_addr,
  output logic [63:0]       mem_wb_data,
  input  logic              mem_credit
);

  localparam int CREDIT_BITS = writeback_pkg::CREDIT_BITS;

  writeback_pkg::wb_entry_t held;
  logic                     full;
  logic                     issue;
  logic [CREDIT_BITS-1:0]   mem_count;

  assign issue = full && (mem_count != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      full         <= 1'b0;
      mem_count    <= CREDIT_BITS'(MEM_CREDITS);
      mem_wb_valid <= 1'b0;
      in_wb.credit <= 1'b0;
    end else begin
      if (in_wb.push) begin
        full <= 1'b1;
      end else if (issue) begin
        full <= 1'b0;
      end
      mem_count    <= mem_count - CREDIT_BITS'(issue) + CREDIT_BITS'(mem_credit);
      mem_wb_valid <= issue;
      // the only slot is free again
      in_wb.credit <= issue;
    end
  end

  always_ff @(posedge clock) begin
    if (in_wb.push) begin
      held <= in_wb.entry;
    end
    if (issue) begin
      mem_wb_addr <= held.addr;
      mem_wb_data <= held.data;
    end
  end

  // the entry on the bus still holds one memory credit
  a_mem_credit_held: assert property (
    @(posedge clock) disable iff (reset) mem_wb_valid |-> mem_count < CREDIT_BITS'(MEM_CREDITS)
  );

endmodule

/* hw/dcache_subsystem.sv */
// top level: data cache, write-back buffer and drain stage on plain ports

`timescale 1ns/100ps

module dcache_subsystem #(
  parameter int NUM_SETS    = 16,
  parameter int WB_DEPTH    = 4,
  parameter int MEM_CREDITS = 2
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                req_valid,
  input  dcache_pkg::req_op_e req_op,
  input  dcache_pkg::addr_t   req_addr,
  input  logic [63:0]         req_data,
  output logic                req_ready,
  output logic                resp_valid,
  output logic                resp_hit,
  output logic [63:0]         resp_data,
  output logic                mem_wb_valid,
  output dcache_pkg::addr_t   mem_wb_addr,
  output logic [63:0]         mem_wb_data,
  input  logic                mem_credit
);

  // cache to buffer, then buffer to drain
  writeback_if wb_fill ();
  writeback_if wb_drain ();

  dcache #(
    .NUM_SETS (NUM_SETS),
    .WB_DEPTH (WB_DEPTH)
  ) u_dcache (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_data   (req_data),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_data  (resp_data),
    .wb         (wb_fill)
  );

  writeback_buffer #(.WB_DEPTH(WB_DEPTH)) u_buffer (
    .clock  (clock),
    .reset  (reset),
    .in_wb  (wb_fill),
    .out_wb (wb_drain)
  );

  writeback_drain #(.MEM_CREDITS(MEM_CREDITS)) u_drain (
    .clock        (clock),
    .reset        (reset),
    .in_wb        (wb_drain),
    .mem_wb_valid (mem_wb_valid),
    .mem_wb_addr  (mem_wb_addr),
    .mem_wb_data  (mem_wb_data),
    .mem_credit   (mem_credit)
  );

endmodule

/* test/clock_gen.sv */
// clock generator with a two-cycle synchronous reset

`timescale 1ns/100ps

module clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // released just after an edge, in step with the stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;
  end

endmodule

/* test/tb_dcache_subsystem.sv */
// testbench: directed and random cache traffic, reference cache model, checks, timeout

`timescale 1ns/100ps

module tb_dcache_subsystem;

  localparam int NUM_SETS = 16;
  localparam int WB_DEPTH = 4;
  localparam int MEM_CREDITS = 2;
  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int OFFSET_BITS = dcache_pkg::OFFSET_BITS;
  localparam int DIRECTED_REQUESTS = 30;
  localparam int HOLD_REQUESTS = 120;
  localparam int FREE_REQUESTS = 80;
  localparam int CYCLE_LIMIT = 20 * (DIRECTED_REQUESTS + HOLD_REQUESTS + FREE_REQUESTS);
  localparam logic [31:0] SEED = 32'hc242ab35;

  typedef struct packed {
    logic        is_load;
    logic        hit;
    logic [63:0] data;
  } resp_t;

  logic                clock;
  logic                reset;
  logic                req_valid;
  dcache_pkg::req_op_e req_op;
  dcache_pkg::addr_t   req_addr;
  logic [63:0]         req_data;
  logic                req_ready;
  logic                resp_valid;
  logic                resp_hit;
  logic [63:0]         resp_data;
  logic                mem_wb_valid;
  dcache_pkg::addr_t   mem_wb_addr;
  logic [63:0]         mem_wb_data;
  logic                mem_credit;

  // reference model, four ways per set
  bit                    ref_valid [NUM_SETS][4];
  bit                    ref_dirty [NUM_SETS][4];
  bit [31-OFFSET_BITS:0] ref_tag   [NUM_SETS][4];
  bit [63:0]             ref_data  [NUM_SETS][4];
  bit                    ref_a [NUM_SETS];
  bit                    ref_b [NUM_SETS];
  bit                    ref_c [NUM_SETS];

  resp_t                    exp_resp [$];
  writeback_pkg::wb_entry_t exp_wb [$];
  writeback_pkg::wb_entry_t wb_log [$];
  bit [31:0]                recent [8];
  int                       recent_ptr;
  logic                     last_hit;
  logic [63:0]              last_data;
  int resp_errors;
  int wb_errors;
  int flow_errors;
  int cycle_count;
  int owed;
  int hold_off;
  int low_cycles;
  bit hold_credits;
  bit random_delay;
  bit ready_low_seen;

  clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  dcache_subsystem #(
    .NUM_SETS    (NUM_SETS),
    .WB_DEPTH    (WB_DEPTH),
    .MEM_CREDITS (MEM_CREDITS)
  ) uut (
    .clock        (clock),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_op       (req_op),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .resp_hit     (resp_hit),
    .resp_data    (resp_data),
    .mem_wb_valid (mem_wb_valid),
    .mem_wb_addr  (mem_wb_addr),
    .mem_wb_data  (mem_wb_data),
    .mem_credit   (mem_credit)
  );

  function automatic dcache_pkg::addr_t make_addr(input int tag_hi, input int set);
    return (32'(tag_hi) << (OFFSET_BITS + INDEX_BITS)) | (32'(set) << OFFSET_BITS);
  endfunction

  function automatic logic [63:0] pattern(input int tag_hi, input int set);
    return {32'hda7a0000 + 32'(set), 32'h0bad0000 + 32'(tag_hi)};
  endfunction

  // expected response of one accepted request; queues a write-back for dirty evictions
  function automatic void predict(input dcache_pkg::req_op_e op, input dcache_pkg::addr_t addr,
                                  input logic [63:0] data, output logic hit,
                                  output logic [63:0] rdata);
    int set;
    int way;
    int victim;
    bit [31-OFFSET_BITS:0] tag;
    writeback_pkg::wb_entry_t evicted;
    set = int'(addr[OFFSET_BITS +: INDEX_BITS]);
    tag = addr[31:OFFSET_BITS];
    hit = 1'b0;
    rdata = '0;
    way = 0;
    for (int w = 0; w < 4; w++) begin
      if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (op == dcache_pkg::op_load && hit) begin
      rdata = ref_data[set][way];
    end else if (op == dcache_pkg::op_store && hit) begin
      ref_data[set][way] = data;
      ref_dirty[set][way] = 1'b1;
    end else if (op == dcache_pkg::op_fill) begin
      victim = ref_a[set] ? (ref_c[set] ? 3 : 2) : (ref_b[set] ? 1 : 0);
      if (!hit) begin
        way = victim;
        if (ref_valid[set][way] && ref_dirty[set][way]) begin
          evicted.addr = {ref_tag[set][way], {OFFSET_BITS{1'b0}}};
          evicted.data = ref_data[set][way];
          exp_wb.push_back(evicted);
        end
      end
      ref_valid[set][way] = 1'b1;
      ref_dirty[set][way] = 1'b0;
      ref_tag[set][way] = tag;
      ref_data[set][way] = data;
      if (ref_a[set]) ref_c[set] = ~ref_c[set];
      else ref_b[set] = ~ref_b[set];
      ref_a[set] = ~ref_a[set];
    end
  endfunction

  // drives one request and returns 2 ns after the accepting edge
  task automatic issue(input dcache_pkg::req_op_e op, input dcache_pkg::addr_t addr,
                       input logic [63:0] data);
    logic        ready_seen;
    logic        hit;
    logic [63:0] rdata;
    resp_t       expected;
    req_valid = 1'b1;
    req_op = op;
    req_addr = addr;
    req_data = data;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      @(negedge clock);
      ready_seen = req_ready;
      @(posedge clock);
    end
    predict(op, addr, data, hit, rdata);
    expected.is_load = (op == dcache_pkg::op_load);
    expected.hit = hit;
    expected.data = rdata;
    exp_resp.push_back(expected);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      #2;
    end
  endtask

  task automatic wait_responses();
    while (exp_resp.size() != 0) settle(1);
  endtask

  // one request with hand-derived expectations on top of the model
  task automatic check_request(input dcache_pkg::req_op_e op, input dcache_pkg::addr_t addr,
                               input logic [63:0] data, input logic hit,
                               input logic [63:0] rdata);
    issue(op, addr, data);
    wait_responses();
    assert (last_hit == hit && (op != dcache_pkg::op_load || !hit || last_data == rdata))
    else begin
      resp_errors++;
      $display("** Error at %0t: %s %h gave hit %0b data %h, expected hit %0b data %h",
               $time, op.name(), addr, last_hit, last_data, hit, rdata);
    end
  endtask

  task automatic random_traffic(input int count);
    int unsigned pick;
    dcache_pkg::addr_t addr;
    logic [63:0] data;
    for (int i = 0; i < count; i++) begin
      pick = $urandom % 100;
      data = {$urandom, $urandom};
      if (pick < 45) begin
        addr = make_addr(int'($urandom % 12), 8 + int'($urandom % 2));
        recent[recent_ptr] = addr;
        recent_ptr = (recent_ptr + 1) % 8;
        issue(dcache_pkg::op_fill, addr, data);
      end else if (pick < 85) begin
        issue(dcache_pkg::op_store, recent[$urandom % 8], data);
      end else begin
        issue(dcache_pkg::op_load, recent[$urandom % 8], '0);
      end
    end
  endtask

  // comparison of responses and memory write-backs
  initial begin
    resp_t expected;
    writeback_pkg::wb_entry_t wb_expected;
    writeback_pkg::wb_entry_t wb_seen;
    forever begin
      @(negedge clock);
      if (!reset && resp_valid) begin
        assert (exp_resp.size() != 0) else begin
          flow_errors++;
          $display("response at %0t with no request outstanding", $time);
        end
        if (exp_resp.size() != 0) begin
          expected = exp_resp.pop_front();
          assert (resp_hit == expected.hit) else begin
            resp_errors++;
            $display("** Error at %0t: hit %0b, expected %0b", $time, resp_hit, expected.hit);
          end
          if (expected.is_load && expected.hit) begin
            assert (resp_data == expected.data) else begin
              resp_errors++;
              $display("** Error at %0t: load data %h, expected %h",
                       $time, resp_data, expected.data);
            end
          end
        end
        last_hit = resp_hit;
        last_data = resp_data;
      end
      if (!reset && mem_wb_valid) begin
        wb_seen.addr = mem_wb_addr;
        wb_seen.data = mem_wb_data;
        wb_log.push_back(wb_seen);
        assert (exp_wb.size() != 0) else begin
          flow_errors++;
          $display("write-back reached memory at %0t with none expected", $time);
        end
        if (exp_wb.size() != 0) begin
          wb_expected = exp_wb.pop_front();
          assert (wb_seen == wb_expected) else begin
            wb_errors++;
            $display("** Error at %0t: write-back %h/%h, expected %h/%h", $time,
                     wb_seen.addr, wb_seen.data, wb_expected.addr, wb_expected.data);
          end
        end
      end
    end
  end

  // memory side: one credit back per write-back, at once or after a hold-off
  initial begin
    mem_credit = 1'b0;
    forever begin
      @(posedge clock);
      #2;
      mem_credit = 1'b0;
      if (mem_wb_valid) owed++;
      if (hold_credits && !req_ready) begin
        ready_low_seen = 1'b1;
        low_cycles++;
      end
      if (low_cycles >= 8) hold_credits = 1'b0;
      if (!hold_credits && owed > 0) begin
        if (hold_off > 0) begin
          hold_off--;
        end else begin
          mem_credit = 1'b1;
          owed--;
          hold_off = random_delay ? int'($urandom % 5) : 0;
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int base;
    void'($urandom(SEED));
    req_valid = 1'b0;
    req_op = dcache_pkg::op_load;
    req_addr = '0;
    req_data = '0;
    #1;
    wait (reset == 1'b0);
    @(negedge clock);
    assert (req_ready === 1'b1 && mem_wb_valid === 1'b0) else begin
      flow_errors++;
      $display("** Error at %0t: after reset req_ready %b mem_wb_valid %b",
               $time, req_ready, mem_wb_valid);
    end
    @(posedge clock);
    #2;
    for (int s = 0; s < 4; s++) check_request(dcache_pkg::op_load, make_addr(s, s), '0, 0, '0);

    // hits, store hit, store miss
    check_request(dcache_pkg::op_fill, make_addr(5, 1), pattern(5, 1), 0, '0);
    check_request(dcache_pkg::op_load, make_addr(5, 1), '0, 1, pattern(5, 1));
    check_request(dcache_pkg::op_store, make_addr(5, 1), 64'h5707e0001, 1, '0);
    check_request(dcache_pkg::op_load, make_addr(5, 1), '0, 1, 64'h5707e0001);
    check_request(dcache_pkg::op_store, make_addr(6, 1), 64'h5707e0002, 0, '0);
    check_request(dcache_pkg::op_load, make_addr(6, 1), '0, 0, '0);
    check_request(dcache_pkg::op_load, make_addr(5, 1), '0, 1, 64'h5707e0001);

    // tree from reset picks ways 0, 2, 1, 3, then way 0 again
    base = wb_log.size();
    for (int t = 1; t <= 5; t++) check_request(dcache_pkg::op_fill, make_addr(t, 3), pattern(t, 3), 0, '0);
    check_request(dcache_pkg::op_load, make_addr(1, 3), '0, 0, '0);
    for (int t = 2; t <= 5; t++) check_request(dcache_pkg::op_load, make_addr(t, 3), '0, 1, pattern(t, 3));
    settle(10);
    assert (wb_log.size() == base) else begin
      flow_errors++;
      $display("clean evictions in set 3 produced a write-back");
    end

    // dirty tags 1 and 3 leave in that order, clean tag 2 leaves silently
    base = wb_log.size();
    for (int t = 1; t <= 4; t++) check_request(dcache_pkg::op_fill, make_addr(t, 5), pattern(t, 5), 0, '0);
    check_request(dcache_pkg::op_store, make_addr(1, 5), 64'hd1e7_0001, 1, '0);
    check_request(dcache_pkg::op_store, make_addr(3, 5), 64'hd1e7_0003, 1, '0);
    for (int t = 5; t <= 7; t++) check_request(dcache_pkg::op_fill, make_addr(t, 5), pattern(t, 5), 0, '0);
    while (exp_wb.size() != 0) settle(1);
    settle(10);
    assert (wb_log.size() == base + 2) else begin
      wb_errors++;
      $display("** Error at %0t: %0d write-backs from set 5, expected 2", $time, wb_log.size() - base);
    end
    if (wb_log.size() == base + 2) begin
      assert (wb_log[base].addr == make_addr(1, 5) && wb_log[base].data == 64'hd1e7_0001 &&
              wb_log[base + 1].addr == make_addr(3, 5) && wb_log[base + 1].data == 64'hd1e7_0003)
      else begin
        wb_errors++;
        $display("** Error at %0t: set 5 write-backs %h then %h", $time,
                 wb_log[base].addr, wb_log[base + 1].addr);
      end
    end

    // memory withholds credits until req_ready has stayed low a while
    random_delay = 1'b1;
    low_cycles = 0;
    hold_credits = 1'b1;
    random_traffic(HOLD_REQUESTS);
    hold_credits = 1'b0;
    random_traffic(FREE_REQUESTS);
    wait_responses();
    while (exp_wb.size() != 0) settle(1);
    settle(10);
    assert (ready_low_seen) else begin
      flow_errors++;
      $display("req_ready never dropped while memory credits were withheld");
    end

    $display("summary: %0d response errors, %0d write-back errors, %0d other errors",
             resp_errors, wb_errors, flow_errors);
    if (resp_errors + wb_errors + flow_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* dcache_subsystem.f */
hw/dcache_pkg.sv
hw/writeback_pkg.sv
hw/writeback_if.sv
hw/cache_way.sv
hw/dcache.sv
hw/writeback_buffer.sv
hw/writeback_drain.sv
hw/dcache_subsystem.sv
test/clock_gen.sv
test/tb_dcache_subsystem.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_dcache_subsystem
FILELIST   := dcache_subsystem.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := >>> FAIL
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
